//--- hw/exec_pkg.sv
package exec_pkg;

    // ALU opcodes.
    localparam logic [3:0] ALU_ADD = 4'd0;
    localparam logic [3:0] ALU_SUB = 4'd1;
    localparam logic [3:0] ALU_AND = 4'd2;
    localparam logic [3:0] ALU_OR  = 4'd3;
    localparam logic [3:0] ALU_XOR = 4'd4;
    localparam logic [3:0] ALU_SLT = 4'd5;
    localparam logic [3:0] ALU_EQ  = 4'd6; // branch conditions return 0 or 1 in bit 0.
    localparam logic [3:0] ALU_NE  = 4'd7;
    localparam logic [3:0] ALU_LT  = 4'd8;
    localparam logic [3:0] ALU_GE  = 4'd9;

    // multiplier opcodes.
    localparam logic [3:0] MUL_NOP = 4'd0;
    localparam logic [3:0] MUL_LO  = 4'd1;
    localparam logic [3:0] MUL_HI  = 4'd2;

    // divider opcodes.
    localparam logic [3:0] DIV_NOP = 4'd0;
    localparam logic [3:0] DIV_DIV = 4'd1;
    localparam logic [3:0] DIV_REM = 4'd2;

    // shifter opcodes. SH_SR is arithmetic unless the unsigned flag is set.
    localparam logic [1:0] SH_NOP = 2'd0;
    localparam logic [1:0] SH_SLL = 2'd1;
    localparam logic [1:0] SH_SR  = 2'd2;

    // start value of the hold counter after a jump is taken.
    localparam logic [2:0] BRANCH_STALL = 3'd2;

endpackage

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [3:0]  alu_op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic        unsigned_flag_i,
    output logic [31:0] result_o,
    output logic        unknown_op_o
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        lt;
    logic        eq;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;
    assign eq   = (a_i == b_i);

    // one less-than serves slt, blt and bge alike.
    assign lt = unsigned_flag_i ? (a_i < b_i) : ($signed(a_i) < $signed(b_i));

    always_comb begin
        result_o     = '0;
        unknown_op_o = 1'b0;
        case (alu_op_i)
            exec_pkg::ALU_ADD: result_o = sum;
            exec_pkg::ALU_SUB: result_o = diff;
            exec_pkg::ALU_AND: result_o = a_i & b_i;
            exec_pkg::ALU_OR:  result_o = a_i | b_i;
            exec_pkg::ALU_XOR: result_o = a_i ^ b_i;
            exec_pkg::ALU_SLT: result_o = {31'd0, lt};
            exec_pkg::ALU_EQ:  result_o = {31'd0, eq};
            exec_pkg::ALU_NE:  result_o = {31'd0, !eq};
            exec_pkg::ALU_LT:  result_o = {31'd0, lt};
            exec_pkg::ALU_GE:  result_o = {31'd0, !lt};
            default: begin
                unknown_op_o = 1'b1; // result stays zero.
            end
        endcase
    end

endmodule

//--- hw/mul.sv
`timescale 1ns/1ps

module mul (
    input  logic [3:0]  mul_op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic        unsigned_flag_i,
    output logic [31:0] result_o,
    output logic        unknown_op_o
);

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] prod;

    // a 33rd bit lets one signed multiplier cover both signedness modes.
    assign a_ext = {!unsigned_flag_i && a_i[31], a_i};
    assign b_ext = {!unsigned_flag_i && b_i[31], b_i};
    assign prod  = a_ext * b_ext;

    always_comb begin
        result_o     = '0;
        unknown_op_o = 1'b0;
        case (mul_op_i)
            exec_pkg::MUL_NOP: result_o = '0;
            exec_pkg::MUL_LO:  result_o = prod[31:0];
            exec_pkg::MUL_HI:  result_o = prod[63:32];
            default:           unknown_op_o = 1'b1;
        endcase
    end

endmodule

//--- hw/div.sv
`timescale 1ns/1ps

module div (
    input  logic        clk,
    input  logic        reset,
    input  logic        kick_i,
    input  logic        unsigned_flag_i,
    input  logic [31:0] dividend_i,
    input  logic [31:0] divider_i,
    output logic        ready_o,
    output logic        ready_pre_o,
    output logic [31:0] quotient_o,
    output logic [31:0] remainder_o
);

    logic [5:0]  count;
    logic [31:0] rem;
    logic [31:0] quo;
    logic [31:0] dvs;
    logic [32:0] trial;
    logic [32:0] diff;
    logic        a_neg;
    logic        b_neg;

    // operands are held stable by the caller for the whole division.
    assign a_neg = !unsigned_flag_i && dividend_i[31];
    assign b_neg = !unsigned_flag_i && divider_i[31];

    assign trial = {rem, quo[31]};
    assign diff  = trial - {1'b0, dvs}; // bit 32 set means the trial subtract failed.

    assign ready_o     = (count == 6'd0);
    assign ready_pre_o = (count <= 6'd1);

    // 32 step cycles followed by one cycle of sign fixing.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (kick_i) begin
            count <= 6'd33;
        end else if (count != 6'd0) begin
            count <= count - 6'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (kick_i) begin
            rem <= '0;
            quo <= a_neg ? -dividend_i : dividend_i;
            dvs <= b_neg ? -divider_i : divider_i;
        end else if (count > 6'd1) begin
            if (!diff[32]) begin
                rem <= diff[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end else if (count == 6'd1) begin
            if (divider_i == '0) begin
                quotient_o  <= '1;
                remainder_o <= dividend_i;
            end else begin
                // the most negative number over minus one wraps back to the dividend here.
                quotient_o  <= (a_neg ^ b_neg) ? -quo : quo;
                remainder_o <= a_neg ? -rem : rem; // remainder takes the dividend's sign.
            end
        end
    end

endmodule

//--- hw/shift.sv
`timescale 1ns/1ps

module shift (
    input  logic        clk,
    input  logic        reset,
    input  logic        kick_i,
    input  logic        unsigned_flag_i,
    input  logic        lshift_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic        ready_o,
    output logic        ready_pre_o,
    output logic [31:0] q_o
);

    logic [4:0] count;
    logic       fill;

    assign ready_o     = (count == 5'd0);
    assign ready_pre_o = (count <= 5'd1);
    assign fill        = !unsigned_flag_i && q_o[31]; // sign bit for arithmetic right shifts.

    // only the low five bits of the amount count, as in RV32.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (kick_i) begin
            count <= b_i[4:0];
        end else if (count != 5'd0) begin
            count <= count - 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (kick_i) begin
            q_o <= a_i;
        end else if (count != 5'd0) begin
            if (lshift_i) begin
                q_o <= {q_o[30:0], 1'b0};
            end else begin
                q_o <= {fill, q_o[31:1]};
            end
        end
    end

endmodule

//--- hw/executer.sv
`timescale 1ns/1ps

module executer (
    input  logic        clk,
    input  logic        reset,
    input  logic        run_i,
    input  logic        stall_i,
    input  logic [3:0]  alu_op_i,
    input  logic [3:0]  mul_op_i,
    input  logic [3:0]  div_op_i,
    input  logic [1:0]  shift_op_i,
    input  logic [31:0] alu_a_i,
    input  logic [31:0] alu_b_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] imm_value_i,
    input  logic        branch_en_i,
    input  logic        jal_en_i,
    input  logic        jalr_en_i,
    input  logic        unsigned_flag_i,
    output logic [31:0] alu_result_o,
    output logic        alu_unknown_op_o,
    output logic [31:0] addr_out_o,
    output logic        addr_out_en_o,
    output logic        div_ready_pre_o,
    output logic        shift_ready_pre_o,
    output logic        run_o,
    input  logic        mem_to_reg_i,
    output logic        mem_to_reg_o,
    input  logic [1:0]  bytes_i,
    output logic [1:0]  bytes_o,
    input  logic [4:0]  wdata_src_i,
    output logic [4:0]  wdata_src_o,
    input  logic [31:0] wdata_i,
    output logic [31:0] wdata_o,
    input  logic        we_i,
    output logic        we_o,
    input  logic        re_i,
    output logic        re_o,
    input  logic [4:0]  rd_i,
    output logic [4:0]  rd_o,
    input  logic        reg_we_i,
    output logic        reg_we_o,
    output logic        unsigned_flag_o
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_JUMP  = 2'd1;
    localparam logic [1:0] ST_DIV   = 2'd2;
    localparam logic [1:0] ST_SHIFT = 2'd3;

    logic [31:0] alu_r;
    logic [31:0] mul_r;
    logic        alu_unk;
    logic        mul_unk;
    logic [31:0] jump_target;
    logic        jump_en;
    logic        div_kick;
    logic        div_ready;
    logic [31:0] div_quotient;
    logic [31:0] div_remainder;
    logic        shift_kick;
    logic        shift_ready;
    logic        shift_pre;
    logic [31:0] shift_q;
    logic [31:0] opnd_a;
    logic [31:0] opnd_b;
    logic        opnd_unsigned;
    logic        opnd_lshift;
    logic [3:0]  div_op_q;
    logic [1:0]  state;
    logic [2:0]  hold_cnt;
    logic        shift_zero;
    logic        accept;
    logic        div_done;
    logic        shift_done;
    logic        div_valid;

    assign accept     = (state == ST_IDLE) && run_i && !stall_i;
    assign div_done   = (state == ST_DIV) && !div_kick && div_ready;
    assign shift_done = (state == ST_SHIFT) && !shift_kick && shift_ready;
    assign div_valid  = (div_op_q == exec_pkg::DIV_DIV) || (div_op_q == exec_pkg::DIV_REM);

    // jalr takes the ALU sum, the others take pc plus the immediate.
    assign jump_target = jalr_en_i ? {alu_r[31:1], 1'b0} : pc_i + imm_value_i;
    assign jump_en     = jal_en_i || jalr_en_i || (branch_en_i && alu_r[0]);

    assign shift_ready_pre_o = shift_pre || shift_zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= ST_IDLE;
            hold_cnt         <= '0;
            run_o            <= 1'b0;
            reg_we_o         <= 1'b0;
            we_o             <= 1'b0;
            re_o             <= 1'b0;
            mem_to_reg_o     <= 1'b0;
            addr_out_en_o    <= 1'b0;
            alu_unknown_op_o <= 1'b0;
            div_kick         <= 1'b0;
            shift_kick       <= 1'b0;
            shift_zero       <= 1'b0;
        end else begin
            run_o      <= run_i;
            div_kick   <= 1'b0; // kicks are single-cycle pulses.
            shift_kick <= 1'b0;
            shift_zero <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        reg_we_o      <= reg_we_i;
                        we_o          <= we_i;
                        re_o          <= re_i;
                        mem_to_reg_o  <= mem_to_reg_i;
                        addr_out_en_o <= jump_en;
                        if (shift_op_i != exec_pkg::SH_NOP) begin
                            alu_unknown_op_o <= 1'b0;
                            if (alu_b_i == '0) begin
                                shift_zero <= 1'b1;
                            end else begin
                                shift_kick <= 1'b1;
                                reg_we_o   <= 1'b0;
                                state      <= ST_SHIFT;
                            end
                        end else if (div_op_i != exec_pkg::DIV_NOP) begin
                            div_kick <= 1'b1;
                            reg_we_o <= 1'b0;
                            state    <= ST_DIV;
                        end else if (mul_op_i != exec_pkg::MUL_NOP) begin
                            alu_unknown_op_o <= mul_unk;
                        end else begin
                            alu_unknown_op_o <= alu_unk;
                        end
                        if (jump_en) begin
                            state    <= ST_JUMP;
                            hold_cnt <= exec_pkg::BRANCH_STALL;
                        end
                    end
                end
                ST_JUMP: begin
                    addr_out_en_o <= 1'b0;
                    if (hold_cnt == 3'd0) begin
                        state <= ST_IDLE;
                    end else begin
                        hold_cnt <= hold_cnt - 3'd1;
                    end
                end
                ST_DIV: begin
                    if (div_done) begin
                        reg_we_o         <= div_valid; // an undefined op never writes.
                        alu_unknown_op_o <= !div_valid;
                        state            <= ST_IDLE;
                    end
                end
                default: begin
                    if (shift_done) begin
                        reg_we_o <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // results, targets and pass-through payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            bytes_o         <= bytes_i;
            wdata_src_o     <= wdata_src_i;
            wdata_o         <= wdata_i;
            rd_o            <= rd_i;
            unsigned_flag_o <= unsigned_flag_i;
            addr_out_o      <= jump_target;
            opnd_a          <= alu_a_i;
            opnd_b          <= alu_b_i;
            opnd_unsigned   <= unsigned_flag_i;
            opnd_lshift     <= (shift_op_i == exec_pkg::SH_SLL);
            div_op_q        <= div_op_i;
            if (shift_op_i != exec_pkg::SH_NOP) begin
                if (alu_b_i == '0) begin
                    alu_result_o <= alu_a_i;
                end
            end else if (div_op_i == exec_pkg::DIV_NOP) begin
                alu_result_o <= (mul_op_i != exec_pkg::MUL_NOP) ? mul_r : alu_r;
            end
        end else if (div_done) begin
            if (div_op_q == exec_pkg::DIV_DIV) begin
                alu_result_o <= div_quotient;
            end else if (div_op_q == exec_pkg::DIV_REM) begin
                alu_result_o <= div_remainder;
            end
        end else if (shift_done) begin
            alu_result_o <= shift_q;
        end
    end

    alu u_alu (
        .alu_op_i        (alu_op_i),
        .a_i             (alu_a_i),
        .b_i             (alu_b_i),
        .unsigned_flag_i (unsigned_flag_i),
        .result_o        (alu_r),
        .unknown_op_o    (alu_unk)
    );

    mul u_mul (
        .mul_op_i        (mul_op_i),
        .a_i             (alu_a_i),
        .b_i             (alu_b_i),
        .unsigned_flag_i (unsigned_flag_i),
        .result_o        (mul_r),
        .unknown_op_o    (mul_unk)
    );

    div u_div (
        .clk             (clk),
        .reset           (reset),
        .kick_i          (div_kick),
        .unsigned_flag_i (opnd_unsigned),
        .dividend_i      (opnd_a),
        .divider_i       (opnd_b),
        .ready_o         (div_ready),
        .ready_pre_o     (div_ready_pre_o),
        .quotient_o      (div_quotient),
        .remainder_o     (div_remainder)
    );

    shift u_shift (
        .clk             (clk),
        .reset           (reset),
        .kick_i          (shift_kick),
        .unsigned_flag_i (opnd_unsigned),
        .lshift_i        (opnd_lshift),
        .a_i             (opnd_a),
        .b_i             (opnd_b),
        .ready_o         (shift_ready),
        .ready_pre_o     (shift_pre),
        .q_o             (shift_q)
    );

endmodule

//--- bench/executer_tb.sv
`timescale 1ns/1ps

module executer_tb;

    logic        clk;
    logic        reset;
    logic        run_i;
    logic        stall_i;
    logic [3:0]  alu_op_i;
    logic [3:0]  mul_op_i;
    logic [3:0]  div_op_i;
    logic [1:0]  shift_op_i;
    logic [31:0] alu_a_i;
    logic [31:0] alu_b_i;
    logic [31:0] pc_i;
    logic [31:0] imm_value_i;
    logic        branch_en_i;
    logic        jal_en_i;
    logic        jalr_en_i;
    logic        unsigned_flag_i;
    logic [31:0] alu_result_o;
    logic        alu_unknown_op_o;
    logic [31:0] addr_out_o;
    logic        addr_out_en_o;
    logic        div_ready_pre_o;
    logic        shift_ready_pre_o;
    logic        run_o;
    logic        mem_to_reg_i;
    logic        mem_to_reg_o;
    logic [1:0]  bytes_i;
    logic [1:0]  bytes_o;
    logic [4:0]  wdata_src_i;
    logic [4:0]  wdata_src_o;
    logic [31:0] wdata_i;
    logic [31:0] wdata_o;
    logic        we_i;
    logic        we_o;
    logic        re_i;
    logic        re_o;
    logic [4:0]  rd_i;
    logic [4:0]  rd_o;
    logic        reg_we_i;
    logic        reg_we_o;
    logic        unsigned_flag_o;

    int          errors;
    int          checks;
    int          test_errors;
    int          kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_val;
    logic [31:0] exp_addr;
    logic [31:0] held;
    logic [3:0]  op;
    logic        uns;
    logic        pre;
    logic        pre_sh;
    logic        taken;

    executer u_executer (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("Fail %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic finish_test(input string name, input int ops);
        $display("%s: %0d ops, %0d errors", name, ops, test_errors);
        test_errors = 0;
    endtask

    // operands come from a, b and uns. Jump enables are cleared.
    task automatic set_op(input logic [3:0] aop, input logic [3:0] mop, input logic [3:0] dop,
                          input logic [1:0] sop);
        alu_op_i        = aop;
        mul_op_i        = mop;
        div_op_i        = dop;
        shift_op_i      = sop;
        alu_a_i         = a;
        alu_b_i         = b;
        unsigned_flag_i = uns;
        jal_en_i        = 1'b0;
        jalr_en_i       = 1'b0;
        branch_en_i     = 1'b0;
    endtask

    task automatic randomize_side();
        mem_to_reg_i = 1'($urandom_range(0, 1));
        bytes_i      = 2'($urandom_range(0, 3));
        wdata_src_i  = 5'($urandom_range(0, 31));
        wdata_i      = $urandom;
        we_i         = 1'($urandom_range(0, 1));
        re_i         = 1'($urandom_range(0, 1));
        rd_i         = 5'($urandom_range(0, 31));
        reg_we_i     = 1'b1;
    endtask

    // returns one ns after the accept edge.
    task automatic pulse_run();
        run_i = 1'b1;
        @(posedge clk);
        #1;
        run_i = 1'b0;
    endtask

    // both flags hold the ready_pre outputs from the cycle before reg_we_o rose.
    task automatic wait_result(output logic div_pre_seen, output logic shift_pre_seen);
        int   n;
        logic div_prev;
        logic shift_prev;
        n          = 0;
        div_prev   = 1'b0;
        shift_prev = 1'b0;
        while (!reg_we_o && n < 100) begin
            div_prev   = div_ready_pre_o;
            shift_prev = shift_ready_pre_o;
            @(posedge clk);
            #1;
            n++;
        end
        if (!reg_we_o) begin
            errors++;
            test_errors++;
            $display("timeout: reg_we_o did not rise within 100 cycles");
        end
        div_pre_seen   = div_prev;
        shift_pre_seen = shift_prev;
    endtask

    function automatic logic [31:0] alu_model(input logic [3:0] aop, input logic [31:0] x,
                                              input logic [31:0] y, input logic u);
        logic less;
        less = u ? (x < y) : ($signed(x) < $signed(y));
        case (aop)
            exec_pkg::ALU_ADD: return x + y;
            exec_pkg::ALU_SUB: return x - y;
            exec_pkg::ALU_AND: return x & y;
            exec_pkg::ALU_OR:  return x | y;
            exec_pkg::ALU_XOR: return x ^ y;
            exec_pkg::ALU_SLT: return {31'd0, less};
            exec_pkg::ALU_EQ:  return {31'd0, x == y};
            exec_pkg::ALU_NE:  return {31'd0, x != y};
            exec_pkg::ALU_LT:  return {31'd0, less};
            exec_pkg::ALU_GE:  return {31'd0, !less};
            default:           return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mul_model(input logic hi, input logic [31:0] x,
                                              input logic [31:0] y, input logic u);
        logic [63:0] p;
        if (u) begin
            p = {32'd0, x} * {32'd0, y};
        end else begin
            p = $signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y});
        end
        return hi ? p[63:32] : p[31:0];
    endfunction

    function automatic logic [31:0] div_model(input logic want_rem, input logic [31:0] x,
                                              input logic [31:0] y, input logic u);
        int          sx;
        int          sy;
        logic [31:0] q;
        logic [31:0] r;
        sx = x;
        sy = y;
        if (y == 32'd0) begin
            q = '1;
            r = x;
        end else if (!u && x == 32'h8000_0000 && y == 32'hffff_ffff) begin
            q = x;
            r = 32'd0;
        end else if (u) begin
            q = x / y;
            r = x % y;
        end else begin
            q = sx / sy; // truncates toward zero, remainder keeps the dividend's sign.
            r = sx % sy;
        end
        return want_rem ? r : q;
    endfunction

    function automatic logic [31:0] shift_model(input logic left, input logic [31:0] x,
                                                input logic [4:0] amt, input logic u);
        logic signed [31:0] sx;
        sx = x;
        if (left) begin
            return x << amt;
        end
        if (u) begin
            return x >> amt;
        end
        return sx >>> amt;
    endfunction

    initial begin
        void'($urandom(14874));
        errors = 0;
        checks = 0;
        test_errors = 0;
        reset = 1'b1;
        run_i = 1'b0;
        stall_i = 1'b0;
        pc_i = '0;
        imm_value_i = '0;
        a = '0;
        b = '0;
        uns = 1'b0;
        set_op(exec_pkg::ALU_ADD, exec_pkg::MUL_NOP, exec_pkg::DIV_NOP, exec_pkg::SH_NOP);
        randomize_side();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < 200; i++) begin
            op = ($urandom_range(0, 9) == 0) ? 4'($urandom_range(10, 15))
                                             : 4'($urandom_range(0, 9));
            a = $urandom;
            b = ($urandom_range(0, 3) == 0) ? a : $urandom; // equal operands now and then.
            uns = 1'($urandom_range(0, 1));
            set_op(op, exec_pkg::MUL_NOP, exec_pkg::DIV_NOP, exec_pkg::SH_NOP);
            pulse_run();
            wait_result(pre, pre_sh);
            check_value("alu_result_o", alu_result_o, alu_model(op, a, b, uns));
            check_value("alu_unknown_op_o", alu_unknown_op_o, op > exec_pkg::ALU_GE);
        end
        finish_test("alu", 200);

        for (int i = 0; i < 100; i++) begin
            op = 4'($urandom_range(1, 2));
            a = $urandom;
            b = $urandom;
            uns = 1'($urandom_range(0, 1));
            set_op(exec_pkg::ALU_ADD, op, exec_pkg::DIV_NOP, exec_pkg::SH_NOP);
            pulse_run();
            wait_result(pre, pre_sh);
            check_value("alu_result_o", alu_result_o,
                        mul_model(op == exec_pkg::MUL_HI, a, b, uns));
            check_value("alu_unknown_op_o", alu_unknown_op_o, 1'b0);
        end
        finish_test("mul", 100);

        for (int i = 0; i < 60; i++) begin
            kind = $urandom_range(0, 7);
            op = 4'($urandom_range(1, 2));
            a = $urandom;
            b = $urandom >> $urandom_range(0, 31);
            uns = 1'($urandom_range(0, 1));
            if (kind == 0) begin
                b = 32'd0;
            end else if (kind == 1) begin
                a = 32'h8000_0000;
                b = 32'hffff_ffff;
                uns = 1'b0;
            end
            set_op(exec_pkg::ALU_ADD, exec_pkg::MUL_NOP, op, exec_pkg::SH_NOP);
            pulse_run();
            wait_result(pre, pre_sh);
            check_value("alu_result_o", alu_result_o,
                        div_model(op == exec_pkg::DIV_REM, a, b, uns));
            check_value("div_ready_pre_o", pre, 1'b1);
        end
        finish_test("div", 60);

        for (int i = 0; i < 100; i++) begin
            kind = $urandom_range(0, 5);
            op = {2'b00, 2'($urandom_range(1, 2))};
            a = $urandom;
            b = (kind == 0) ? 32'd0 : (kind == 1) ? 32'd31 : 32'($urandom_range(1, 31));
            uns = 1'($urandom_range(0, 1));
            set_op(exec_pkg::ALU_ADD, exec_pkg::MUL_NOP, exec_pkg::DIV_NOP, op[1:0]);
            pulse_run();
            if (b == 32'd0) begin
                check_value("shift_ready_pre_o", shift_ready_pre_o, 1'b1);
            end
            wait_result(pre, pre_sh);
            if (b != 32'd0) begin
                check_value("shift_ready_pre_o", pre_sh, 1'b1);
            end
            check_value("alu_result_o", alu_result_o,
                        shift_model(op[1:0] == exec_pkg::SH_SLL, a, b[4:0], uns));
            check_value("alu_unknown_op_o", alu_unknown_op_o, 1'b0);
        end
        finish_test("shift", 100);

        for (int i = 0; i < 40; i++) begin
            kind = $urandom_range(0, 2); // 0 is jal, 1 is jalr, 2 is a branch.
            a = $urandom;
            b = ($urandom_range(0, 2) == 0) ? a : $urandom;
            uns = 1'($urandom_range(0, 1));
            op = (kind == 2) ? 4'($urandom_range(6, 9)) : exec_pkg::ALU_ADD;
            set_op(op, exec_pkg::MUL_NOP, exec_pkg::DIV_NOP, exec_pkg::SH_NOP);
            pc_i = $urandom;
            imm_value_i = $urandom;
            jal_en_i = (kind == 0);
            jalr_en_i = (kind == 1);
            branch_en_i = (kind == 2);
            exp_val = alu_model(op, a, b, uns);
            taken = (kind != 2) || exp_val[0];
            exp_addr = (kind == 1) ? {exp_val[31:1], 1'b0} : pc_i + imm_value_i;
            pulse_run();
            jal_en_i = 1'b0;
            jalr_en_i = 1'b0;
            branch_en_i = 1'b0;
            check_value("alu_result_o", alu_result_o, exp_val);
            check_value("addr_out_en_o", addr_out_en_o, taken);
            if (taken) begin
                check_value("addr_out_o", addr_out_o, exp_addr);
                @(posedge clk);
                #1;
                check_value("addr_out_en_o", addr_out_en_o, 1'b0);
                held = alu_result_o;
                a = $urandom;
                b = $urandom;
                set_op(exec_pkg::ALU_ADD, exec_pkg::MUL_NOP, exec_pkg::DIV_NOP, exec_pkg::SH_NOP);
                pulse_run(); // lands 2 cycles after the jump and must be dropped.
                check_value("alu_result_o", alu_result_o, held);
                @(posedge clk);
                #1;
                check_value("alu_result_o", alu_result_o, held);
                a = $urandom;
                b = $urandom;
                set_op(exec_pkg::ALU_SUB, exec_pkg::MUL_NOP, exec_pkg::DIV_NOP, exec_pkg::SH_NOP);
                pulse_run();
                check_value("alu_result_o", alu_result_o, a - b);
            end
        end
        finish_test("jump", 40);

        for (int i = 0; i < 40; i++) begin
            randomize_side();
            a = $urandom;
            b = $urandom;
            uns = 1'($urandom_range(0, 1));
            set_op(exec_pkg::ALU_ADD, exec_pkg::MUL_NOP, exec_pkg::DIV_NOP, exec_pkg::SH_NOP);
            pulse_run();
            check_value("mem_to_reg_o", mem_to_reg_o, mem_to_reg_i);
            check_value("bytes_o", bytes_o, bytes_i);
            check_value("wdata_src_o", wdata_src_o, wdata_src_i);
            check_value("wdata_o", wdata_o, wdata_i);
            check_value("we_o", we_o, we_i);
            check_value("re_o", re_o, re_i);
            check_value("rd_o", rd_o, rd_i);
            check_value("unsigned_flag_o", unsigned_flag_o, uns);
            check_value("run_o", run_o, 1'b1);
            @(posedge clk);
            #1;
            check_value("run_o", run_o, 1'b0);
            held = alu_result_o;
            a = $urandom;
            b = $urandom;
            set_op(exec_pkg::ALU_XOR, exec_pkg::MUL_NOP, exec_pkg::DIV_NOP, exec_pkg::SH_NOP);
            stall_i = 1'b1;
            run_i = 1'b1;
            repeat (3) begin
                @(posedge clk);
                #1;
                check_value("alu_result_o", alu_result_o, held);
            end
            stall_i = 1'b0;
            @(posedge clk);
            #1;
            run_i = 1'b0;
            check_value("alu_result_o", alu_result_o, a ^ b);
        end
        finish_test("pass-through and stall", 40);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/exec_pkg.sv
hw/alu.sv
hw/mul.sv
hw/div.sv
hw/shift.sv
hw/executer.sv
bench/executer_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the executer testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f sim.f --top-module executer_tb -o executer_sim || exit 1
out="$(./obj_dir/executer_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TEST RESULT: PASS" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
